// File: design/lycan_pkg.sv
// Shared widths, slot count bound and the host packet struct
package lycan_pkg;

  // Host packet fields
  parameter int addr_width = 4;
  parameter int payload_width = 12;

  // Pins driven by each slot's loopback logic
  parameter int pins_per_periph = 8;

  // Address 0 is reserved, so at most 15 slots fit in a 4-bit address
  parameter int max_periphs = 15;

  // One 16-bit host packet, address in the top nibble
  typedef struct packed {
    logic [addr_width-1:0]    addr;
    logic [payload_width-1:0] payload;
  } usb_packet_t;

endpackage

// File: design/periph_fifo.sv
// Synchronous packet FIFO with full, empty and programmable almost-full flags
module periph_fifo #(
  parameter int DEPTH = 4,
  parameter int ALMOST_FULL_LEVEL = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  lycan_pkg::usb_packet_t din,
  input  logic                  wr_en,
  input  logic                  rd_en,
  output lycan_pkg::usb_packet_t dout,
  output logic                  full,
  output logic                  empty,
  output logic                  almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lycan_pkg::usb_packet_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic do_wr, do_rd;

  assign do_wr = wr_en && !full; // Writes on a full FIFO are dropped
  assign do_rd = rd_en && !empty;

  assign full = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign almost_full = (count >= CNT_W'(ALMOST_FULL_LEVEL));
  assign dout = mem[rd_ptr]; // Head entry, first-word fall-through

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Count only moves when exactly one side acts
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

endmodule

// File: design/loopback_engine.sv
// Loopback engine, stand-in for the reconfigurable slot logic
module loopback_engine (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [lycan_pkg::payload_width-1:0]  tx_payload,
  input  logic                                 tx_empty,
  output logic                                 tx_pop,
  output logic [lycan_pkg::payload_width-1:0]  rx_payload,
  output logic                                 rx_push,
  input  logic                                 rx_full,
  output logic [lycan_pkg::pins_per_periph-1:0] pins,
  output logic                                 idle
);

  logic holding; // One payload in flight
  logic [lycan_pkg::payload_width-1:0] held;

  assign tx_pop = !holding && !tx_empty;
  assign rx_push = holding && !rx_full; // Stall here while the receive side is full
  assign rx_payload = held;
  assign idle = !holding && tx_empty;

  always_ff @(posedge clk) begin
    if (tx_pop) held <= tx_payload;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      holding <= 1'b0;
      pins <= '0;
    end else if (!holding) begin
      if (!tx_empty) begin
        holding <= 1'b1;
        // Low byte stays on the pins until the next payload
        pins <= tx_payload[lycan_pkg::pins_per_periph-1:0];
      end
    end else if (!rx_full) begin
      holding <= 1'b0;
    end
  end

endmodule

// File: design/periph.sv
// Peripheral slot with address filter, transmit and receive FIFOs, ready counter and loopback
module periph #(
  parameter logic [lycan_pkg::addr_width-1:0] ADDRESS = 1,
  parameter int TX_DEPTH = 4,
  parameter int RX_DEPTH = 4,
  parameter int RX_ALMOST_FULL = 3
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  lycan_pkg::usb_packet_t                wr_pkt,
  input  logic                                  wr_strobe,
  output logic                                  tx_full,
  output lycan_pkg::usb_packet_t                rx_pkt,
  input  logic                                  rx_pop,
  output logic                                  rx_empty,
  output logic                                  rx_almost_full,
  output logic                                  idle,
  output logic                                  ready,
  output logic [lycan_pkg::pins_per_periph-1:0] pins
);

  lycan_pkg::usb_packet_t tx_pkt, rx_din;
  logic tx_wr, tx_pop, tx_empty;
  logic rx_push, rx_full;
  logic [lycan_pkg::payload_width-1:0] rx_payload;
  logic [5:0] ready_cnt;

  // Own address filter, the dispatcher only aims the strobe
  assign tx_wr = wr_strobe && (wr_pkt.addr == ADDRESS);
  assign rx_din = '{addr: ADDRESS, payload: rx_payload}; // Re-tag with slot address

  periph_fifo #(.DEPTH(TX_DEPTH), .ALMOST_FULL_LEVEL(TX_DEPTH)) tx_fifo (
    .clk(clk), .rst(rst),
    .din(wr_pkt), .wr_en(tx_wr), .rd_en(tx_pop),
    .dout(tx_pkt), .full(tx_full), .empty(tx_empty), .almost_full()
  );

  loopback_engine engine (
    .clk(clk), .rst(rst),
    .tx_payload(tx_pkt.payload), .tx_empty(tx_empty), .tx_pop(tx_pop),
    .rx_payload(rx_payload), .rx_push(rx_push), .rx_full(rx_full),
    .pins(pins), .idle(idle)
  );

  periph_fifo #(.DEPTH(RX_DEPTH), .ALMOST_FULL_LEVEL(RX_ALMOST_FULL)) rx_fifo (
    .clk(clk), .rst(rst),
    .din(rx_din), .wr_en(rx_push), .rd_en(rx_pop),
    .dout(rx_pkt), .full(rx_full), .empty(rx_empty), .almost_full(rx_almost_full)
  );

  // 63-cycle quiet period after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ready_cnt <= '0;
    end else if (ready_cnt != '1) begin
      ready_cnt <= ready_cnt + 1'b1;
    end
  end

  assign ready = (ready_cnt == '1);

endmodule

// File: design/packet_dispatcher.sv
// Host packet dispatcher with slot decode and saturating drop counter
module packet_dispatcher #(
  parameter int NUM_PERIPHS = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  lycan_pkg::usb_packet_t host_in,
  input  logic                   host_in_valid,
  input  logic [NUM_PERIPHS-1:0] slot_full,
  output lycan_pkg::usb_packet_t slot_pkt,
  output logic [NUM_PERIPHS-1:0] slot_wr,
  output logic [15:0]            drop_count
);

  logic                   pkt_valid;
  logic [NUM_PERIPHS-1:0] target; // One-hot slot, zero for a bad address

  // Full is checked at write time so back-to-back packets never overrun a FIFO
  assign slot_wr = target & ~slot_full;

  always_ff @(posedge clk) begin
    if (host_in_valid) slot_pkt <= host_in;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pkt_valid <= 1'b0;
      target <= '0;
      drop_count <= '0;
    end else begin
      pkt_valid <= host_in_valid;
      for (int i = 0; i < NUM_PERIPHS; i++) begin
        target[i] <= host_in_valid && (int'(host_in.addr) == i + 1); // Slot i sits at i+1
      end
      // Missing slot or full FIFO
      if (pkt_valid && (slot_wr == '0) && (drop_count != 16'hffff)) begin
        drop_count <= drop_count + 16'd1;
      end
    end
  end

endmodule

// File: design/reply_collector.sv
// Round-robin collector from the slot receive FIFOs toward the host
module reply_collector #(
  parameter int NUM_PERIPHS = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  lycan_pkg::usb_packet_t rx_pkt [NUM_PERIPHS],
  input  logic [NUM_PERIPHS-1:0] rx_empty,
  output logic [NUM_PERIPHS-1:0] rx_pop,
  input  logic                   host_hold,
  output lycan_pkg::usb_packet_t host_out,
  output logic                   host_out_valid
);

  localparam int SEL_W = (NUM_PERIPHS > 1) ? $clog2(NUM_PERIPHS) : 1;

  logic [SEL_W-1:0] last; // Slot served most recently
  logic [SEL_W-1:0] pick;
  logic             found;
  logic             pop_any;

  // Search starts just after the last slot served
  always_comb begin
    int idx;
    rx_pop = '0;
    pick = last;
    found = 1'b0;
    for (int k = 1; k <= NUM_PERIPHS; k++) begin
      idx = (int'(last) + k) % NUM_PERIPHS;
      if (!found && !rx_empty[idx]) begin
        found = 1'b1;
        pick = SEL_W'(idx);
      end
    end
    if (found && !host_hold) rx_pop[pick] = 1'b1; // Hold freezes all pops
  end

  assign pop_any = |rx_pop;

  always_ff @(posedge clk) begin
    if (pop_any) host_out <= rx_pkt[pick];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last <= SEL_W'(NUM_PERIPHS - 1); // So slot 0 goes first
      host_out_valid <= 1'b0;
    end else begin
      host_out_valid <= pop_any;
      if (pop_any) last <= pick;
    end
  end

endmodule

// File: design/lycan_top.sv
// Packet hub top level with dispatcher, slot array and reply collector
module lycan_top #(
  parameter int NUM_PERIPHS = 3,
  parameter int TX_DEPTH = 4,
  parameter int RX_DEPTH = 4,
  parameter int RX_ALMOST_FULL = 3
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  lycan_pkg::usb_packet_t                host_in,
  input  logic                                  host_in_valid,
  input  logic                                  host_hold,
  output lycan_pkg::usb_packet_t                host_out,
  output logic                                  host_out_valid,
  output logic [15:0]                           drop_count,
  output logic [NUM_PERIPHS-1:0]                periph_ready,
  output logic [NUM_PERIPHS-1:0]                periph_idle,
  output logic [NUM_PERIPHS-1:0]                periph_almost_full,
  output logic [lycan_pkg::pins_per_periph-1:0] periph_pins [NUM_PERIPHS]
);

  lycan_pkg::usb_packet_t slot_pkt;
  lycan_pkg::usb_packet_t rx_pkt [NUM_PERIPHS];
  logic [NUM_PERIPHS-1:0] slot_wr, slot_full;
  logic [NUM_PERIPHS-1:0] rx_empty, rx_pop;

  if (NUM_PERIPHS < 1 || NUM_PERIPHS > lycan_pkg::max_periphs) begin : gen_bad_count
    $error("NUM_PERIPHS out of range");
  end

  packet_dispatcher #(.NUM_PERIPHS(NUM_PERIPHS)) dispatcher (
    .clk(clk), .rst(rst),
    .host_in(host_in), .host_in_valid(host_in_valid),
    .slot_full(slot_full), .slot_pkt(slot_pkt), .slot_wr(slot_wr),
    .drop_count(drop_count)
  );

  for (genvar i = 0; i < NUM_PERIPHS; i++) begin : gen_slot
    periph #(
      .ADDRESS(lycan_pkg::addr_width'(i + 1)), // Address 0 stays unused
      .TX_DEPTH(TX_DEPTH),
      .RX_DEPTH(RX_DEPTH),
      .RX_ALMOST_FULL(RX_ALMOST_FULL)
    ) slot (
      .clk(clk), .rst(rst),
      .wr_pkt(slot_pkt), .wr_strobe(slot_wr[i]), .tx_full(slot_full[i]),
      .rx_pkt(rx_pkt[i]), .rx_pop(rx_pop[i]), .rx_empty(rx_empty[i]),
      .rx_almost_full(periph_almost_full[i]),
      .idle(periph_idle[i]), .ready(periph_ready[i]), .pins(periph_pins[i])
    );
  end

  reply_collector #(.NUM_PERIPHS(NUM_PERIPHS)) collector (
    .clk(clk), .rst(rst),
    .rx_pkt(rx_pkt), .rx_empty(rx_empty), .rx_pop(rx_pop),
    .host_hold(host_hold), .host_out(host_out), .host_out_valid(host_out_valid)
  );

endmodule

// File: tests/lycan_props.sv
// Bound assertions on collector hold and pop rules and on slot FIFO writes
module lycan_props #(
  parameter int W = 1
) (
  input logic         clk,
  input logic         rst,
  input logic         hold,
  input logic         out_valid,
  input logic [W-1:0] pop,
  input logic [W-1:0] empty,
  input logic         wr,
  input logic         full
);

  // Output register follows the pop decision one cycle earlier
  assert property (@(posedge clk) disable iff (rst) $past(hold) |-> !out_valid)
    else $error("host_out_valid after a held cycle");

  assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("more than one receive FIFO popped");

  assert property (@(posedge clk) disable iff (rst) (pop & empty) == '0)
    else $error("pop issued on an empty receive FIFO");

  assert property (@(posedge clk) disable iff (rst) !(wr && full))
    else $error("write strobe on a full transmit FIFO");

endmodule

bind reply_collector lycan_props #(.W(NUM_PERIPHS)) collector_props (
  .clk(clk), .rst(rst), .hold(host_hold), .out_valid(host_out_valid),
  .pop(rx_pop), .empty(rx_empty), .wr(1'b0), .full(1'b0)
);

bind periph lycan_props #(.W(1)) slot_props (
  .clk(clk), .rst(rst), .hold(1'b0), .out_valid(1'b0),
  .pop(rx_pop), .empty(rx_empty), .wr(tx_wr), .full(tx_full)
);

// File: tests/lycan_tb.sv
// Hub testbench with file-driven stimulus, per-slot scoreboard, compare tasks and watchdog
module lycan_tb;

  localparam int NUM_PERIPHS = 3;
  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 4;
  localparam int RX_ALMOST_FULL = 3;
  localparam int MAX_LINES = 64;

  logic clk = 1'b0;
  logic rst;
  lycan_pkg::usb_packet_t host_in, host_out;
  logic host_in_valid, host_hold, host_out_valid;
  logic [15:0] drop_count;
  logic [NUM_PERIPHS-1:0] periph_ready, periph_idle, periph_almost_full;
  logic [lycan_pkg::pins_per_periph-1:0] periph_pins [NUM_PERIPHS];

  lycan_pkg::usb_packet_t exp_q [NUM_PERIPHS][$]; // Expected returns per slot
  logic [lycan_pkg::pins_per_periph-1:0] model_pins [NUM_PERIPHS];
  logic [15:0] model_drops;
  int n_expected, n_received, hold_sent, n_lines;
  logic [7:0] lfsr_state;
  logic loaded;

  int rec_op [MAX_LINES]; // 0 send, 1 hold, 2 release
  logic [lycan_pkg::addr_width-1:0] rec_addr [MAX_LINES];
  logic [lycan_pkg::payload_width-1:0] rec_payload [MAX_LINES];
  logic rec_flag [MAX_LINES];

  lycan_top #(
    .NUM_PERIPHS(NUM_PERIPHS), .TX_DEPTH(TX_DEPTH),
    .RX_DEPTH(RX_DEPTH), .RX_ALMOST_FULL(RX_ALMOST_FULL)
  ) dut0 (
    .clk(clk), .rst(rst),
    .host_in(host_in), .host_in_valid(host_in_valid), .host_hold(host_hold),
    .host_out(host_out), .host_out_valid(host_out_valid), .drop_count(drop_count),
    .periph_ready(periph_ready), .periph_idle(periph_idle),
    .periph_almost_full(periph_almost_full), .periph_pins(periph_pins)
  );

  always #4 clk = ~clk;

  // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic value_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "first error");
  endtask

  task automatic check_packet(input lycan_pkg::usb_packet_t got, want, input string what);
    if (got !== want) value_error($sformatf("%s got %h expected %h", what, got, want));
  endtask

  task automatic check_count(input logic [15:0] got, want, input string what);
    if (got !== want) value_error($sformatf("%s got %0d expected %0d", what, got, want));
  endtask

  task automatic check_pins(input logic [lycan_pkg::pins_per_periph-1:0] got, want,
                            input string what);
    if (got !== want) value_error($sformatf("%s got %h expected %h", what, got, want));
  endtask

  task automatic check_flag(input logic got, want, input string what);
    if (got !== want) value_error($sformatf("%s got %b expected %b", what, got, want));
  endtask

  task automatic load_stimulus();
    int fd, code;
    logic [8*96-1:0] text;
    logic [8*7-1:0] op;
    logic [lycan_pkg::addr_width-1:0] a;
    logic [lycan_pkg::payload_width-1:0] p;
    logic f;
    fd = $fopen("tests/lycan_testdata.txt", "r");
    if (fd == 0) abort_run("Cannot open tests/lycan_testdata.txt");
    n_lines = 0;
    text = '0;
    while ($fgets(text, fd) != 0) begin
      code = $sscanf(text, "%s %h %h %h", op, a, p, f);
      if (code == 4) begin // Comment lines stop after the first word
        if (n_lines == MAX_LINES) abort_run("Too many lines in test data");
        if (op == 56'("send")) rec_op[n_lines] = 0;
        else if (op == 56'("hold")) rec_op[n_lines] = 1;
        else if (op == 56'("release")) rec_op[n_lines] = 2;
        else abort_run("Unknown operation in test data");
        rec_addr[n_lines] = a;
        rec_payload[n_lines] = p;
        rec_flag[n_lines] = f;
        n_lines++;
      end
      text = '0;
    end
    $fclose(fd);
    if (n_lines == 0) abort_run("No stimulus lines in test data");
  endtask

  task automatic idle_gap();
    logic [1:0] gap;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap[b] = lfsr_state[0];
    end
    repeat (gap) @(negedge clk);
  endtask

  task automatic send_packet(input logic [lycan_pkg::addr_width-1:0] a,
                             input logic [lycan_pkg::payload_width-1:0] p, input logic drop);
    logic valid;
    valid = (a != '0) && (int'(a) <= NUM_PERIPHS);
    if (drop !== !valid) abort_run("Test data drop flag does not match the slot address range");
    host_in = '{addr: a, payload: p};
    if (valid) begin
      exp_q[int'(a) - 1].push_back(host_in);
      model_pins[int'(a) - 1] = p[lycan_pkg::pins_per_periph-1:0]; // Last low byte stays
      n_expected++;
      if (host_hold) hold_sent++;
    end else begin
      model_drops = model_drops + 16'd1;
    end
    host_in_valid = 1'b1;
    @(negedge clk);
    host_in_valid = 1'b0;
    idle_gap();
  endtask

  task automatic wait_drained();
    while (n_received != n_expected || periph_idle != '1) @(negedge clk);
    repeat (2) @(negedge clk); // Drop counter settles two edges after the last strobe
  endtask

  // Slot chains advance at least every other cycle while they can move
  task automatic wait_stable();
    int steady;
    logic [2*NUM_PERIPHS-1:0] prev;
    steady = 0;
    prev = {periph_idle, periph_almost_full};
    while (steady < 8) begin
      @(negedge clk);
      if ({periph_idle, periph_almost_full} == prev) steady++;
      else steady = 0;
      prev = {periph_idle, periph_almost_full};
    end
  endtask

  task automatic release_hold(input logic [lycan_pkg::addr_width-1:0] a, input logic flag);
    logic want_af;
    logic want_idle;
    wait_stable();
    want_af = (((hold_sent < RX_DEPTH) ? hold_sent : RX_DEPTH) >= RX_ALMOST_FULL);
    want_idle = (hold_sent <= RX_DEPTH); // Beyond RX_DEPTH the engine keeps one payload
    if (flag !== want_af) abort_run("Test data almost-full flag does not match the FIFO rule");
    check_flag(periph_almost_full[int'(a) - 1], want_af, "almost-full under hold");
    check_flag(periph_idle[int'(a) - 1], want_idle, "idle under hold");
    check_count(drop_count, model_drops, "drop count under hold");
    host_hold = 1'b0;
    wait_drained();
  endtask

  // Scoreboard on the host side, sampled mid-cycle
  always @(negedge clk) begin
    lycan_pkg::usb_packet_t want;
    int slot;
    if (!rst && host_out_valid) begin
      slot = int'(host_out.addr) - 1;
      if (slot < 0 || slot >= NUM_PERIPHS || exp_q[slot].size() == 0) begin
        abort_run($sformatf("Packet %h came back with no matching send", host_out));
      end else begin
        want = exp_q[slot].pop_front();
        check_packet(host_out, want, "returned packet");
        n_received++;
      end
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = n_lines * 40 + 2000;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired, run did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

  initial begin
    rst = 1'b1;
    host_in = '0;
    host_in_valid = 1'b0;
    host_hold = 1'b0;
    model_drops = '0;
    n_expected = 0;
    n_received = 0;
    hold_sent = 0;
    lfsr_state = 8'd89;
    loaded = 1'b0;
    for (int i = 0; i < NUM_PERIPHS; i++) model_pins[i] = '0;
    load_stimulus();
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int k = 0; k < 63; k++) begin // Quiet period of the ready counter
      check_flag(|periph_ready, 1'b0, "ready during quiet period");
      @(negedge clk);
    end
    check_flag(&periph_ready, 1'b1, "ready after quiet period");
    check_flag(&periph_idle, 1'b1, "idle after reset");
    for (int i = 0; i < NUM_PERIPHS; i++) check_pins(periph_pins[i], '0, "pins after reset");
    for (int n = 0; n < n_lines; n++) begin
      case (rec_op[n])
        0: send_packet(rec_addr[n], rec_payload[n], rec_flag[n]);
        1: begin
          wait_drained(); // Hold starts from empty slots
          host_hold = 1'b1;
          hold_sent = 0;
        end
        default: release_hold(rec_addr[n], rec_flag[n]);
      endcase
    end
    wait_drained();
    check_count(drop_count, model_drops, "final drop count");
    for (int i = 0; i < NUM_PERIPHS; i++) check_pins(periph_pins[i], model_pins[i], "slot pins");
    if (n_received == n_expected && n_expected > 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "scoreboard saw no returned packets");
    end
  end

endmodule

// File: tests/lycan_testdata.txt
# op address payload flag, all numbers in hex
# send uses flag as expected drop, release names the held slot and its almost-full flag
send 1 0a5 0
send 2 13c 0
send 0 111 1
send 3 2f1 0
send 4 222 1
send 1 0b6 0
send f 3ff 1
hold 0 000 0
send 2 201 0
send 2 202 0
release 2 000 0
hold 0 000 0
send 3 301 0
send 3 302 0
send 3 303 0
send 3 304 0
send 3 3e5 0
release 3 000 1
send 1 0c3 0

// File: verilog.f
design/lycan_pkg.sv
design/periph_fifo.sv
design/loopback_engine.sv
design/periph.sv
design/packet_dispatcher.sv
design/reply_collector.sv
design/lycan_top.sv
tests/lycan_props.sv
tests/lycan_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the hub testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module lycan_tb -f verilog.f --Mdir obj_dir -o lycan_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/lycan_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
exit 0
